/* branch_settings.svh */
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// ##################################################
// predictor geometry
// ##################################################

// log2 of the number of counter / target entries
`define BHT_INDEX_BITS 4

// ##################################################
// branch alu opcodes
// ##################################################

`define ALU_NOP  4'h0
`define ALU_BEQ  4'h1
`define ALU_BNE  4'h2
`define ALU_BLT  4'h3
`define ALU_BGE  4'h4
`define ALU_BLTU 4'h5
`define ALU_BGEU 4'h6
`define ALU_B    4'h7
`define ALU_BL   4'h8
`define ALU_JIRL 4'h9

`endif

/* branch_pkg.sv */
package branch_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [3:0]  alu_op_t;

    // ##################################################
    // instruction word views
    // ##################################################

    // 2RI16 form used by the conditional branches and jirl
    typedef struct packed {
        logic [5:0]  opcode6;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_off16_t;

    // I26 form used by b and bl, offset split across the word
    typedef struct packed {
        logic [5:0]  opcode6;
        logic [15:0] offs_lo16;
        logic [9:0]  offs_hi10;
    } inst_off26_t;

    typedef union packed {
        inst_off16_t off16;
        inst_off26_t off26;
    } inst_word_u;

    // ##################################################
    // pipeline records
    // ##################################################

    typedef struct packed {
        bus32_t     pc;
        inst_word_u inst;
        alu_op_t    aluop;
        bus32_t     reg1;
        bus32_t     reg2;
        logic       pred_taken;
        bus32_t     pred_target;
    } branch_req_t;

    typedef struct packed {
        logic   update_en;
        bus32_t pc_dispatch;
        logic   taken_actual;
        // taken target, zero when not taken
        bus32_t actual_target;
    } branch_update_t;

    typedef struct packed {
        bus32_t         pc;
        bus32_t         link_value;
        logic           flush;
        bus32_t         redirect_addr;
        branch_update_t update;
    } branch_res_t;

    typedef struct packed {
        logic   taken;
        bus32_t target;
    } prediction_t;

endpackage

/* branch_alu.sv */
`include "branch_settings.svh"

module branch_alu (
    input  branch_pkg::bus32_t         pc,
    input  branch_pkg::inst_word_u     inst,
    input  branch_pkg::alu_op_t        aluop,
    input  branch_pkg::bus32_t         reg1,
    input  branch_pkg::bus32_t         reg2,
    input  logic                       pre_is_branch_taken,
    input  branch_pkg::bus32_t         pre_branch_addr,
    output branch_pkg::branch_update_t update_info,
    output logic                       branch_flush,
    output branch_pkg::bus32_t         redirect_addr,
    output branch_pkg::bus32_t         branch_alu_res
);
    import branch_pkg::*;

    logic   reg_eq;
    logic   lt_signed;
    logic   lt_unsigned;
    bus32_t off16;
    bus32_t off26;
    bus32_t pc_plus4;
    logic   is_branch;
    logic   is_taken;
    bus32_t target;
    logic   mispredict;

    // ##################################################
    // compares and offsets
    // ##################################################

    assign reg_eq      = (reg1 == reg2);
    assign lt_signed   = ($signed(reg1) < $signed(reg2));
    assign lt_unsigned = (reg1 < reg2);

    // word offsets, sign extended
    assign off16 = {{14{inst.off16.offs16[15]}}, inst.off16.offs16, 2'b00};
    assign off26 = {{4{inst.off26.offs_hi10[9]}}, inst.off26.offs_hi10,
                    inst.off26.offs_lo16, 2'b00};

    assign pc_plus4 = pc + 32'd4;

    // ##################################################
    // direction, target and link
    // ##################################################

    always_comb begin
        is_branch      = 1'b1;
        is_taken       = 1'b0;
        target         = pc + off16;
        branch_alu_res = '0;
        case (aluop)
            `ALU_BEQ:  is_taken = reg_eq;
            `ALU_BNE:  is_taken = !reg_eq;
            `ALU_BLT:  is_taken = lt_signed;
            `ALU_BGE:  is_taken = !lt_signed;
            `ALU_BLTU: is_taken = lt_unsigned;
            `ALU_BGEU: is_taken = !lt_unsigned;
            `ALU_B: begin
                is_taken = 1'b1;
                target   = pc + off26;
            end
            `ALU_BL: begin
                is_taken       = 1'b1;
                target         = pc + off26;
                branch_alu_res = pc_plus4;
            end
            `ALU_JIRL: begin
                // register-relative jump
                is_taken       = 1'b1;
                target         = reg1 + off16;
                branch_alu_res = pc_plus4;
            end
            `ALU_NOP: begin
                is_branch = 1'b0;
                target    = '0;
            end
            default: begin
                is_branch = 1'b0;
                target    = '0;
            end
        endcase
    end

    // wrong direction, or right direction with a stale target
    assign mispredict = (is_taken != pre_is_branch_taken) ||
                        (is_taken && pre_is_branch_taken && (target != pre_branch_addr));

    assign branch_flush  = is_branch && mispredict;
    assign redirect_addr = is_taken ? target : pc_plus4;

    assign update_info = '{
        update_en:     is_branch,
        pc_dispatch:   pc,
        taken_actual:  is_taken,
        actual_target: is_taken ? target : '0
    };

endmodule

/* branch_predictor.sv */
`include "branch_settings.svh"

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  branch_pkg::bus32_t         fetch_pc,
    output branch_pkg::prediction_t    fetch_pred,
    input  logic                       train_valid,
    input  branch_pkg::branch_update_t train
);
    import branch_pkg::*;

    localparam int IDX_W   = `BHT_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_W   = 32 - IDX_W - 2;

    logic [ENTRIES-1:0][1:0] cnt_q;
    logic [ENTRIES-1:0]      btb_valid_q;
    logic [TAG_W-1:0]        btb_tag_q [ENTRIES];
    bus32_t                  btb_target_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             hit;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    // ##################################################
    // lookup
    // ##################################################

    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign rd_tag = fetch_pc[31:IDX_W+2];

    assign hit = btb_valid_q[rd_idx] && (btb_tag_q[rd_idx] == rd_tag);

    assign fetch_pred.taken  = cnt_q[rd_idx][1] && hit;
    assign fetch_pred.target = (cnt_q[rd_idx][1] && hit) ? btb_target_q[rd_idx] : '0;

    // ##################################################
    // training
    // ##################################################

    assign wr_idx = train.pc_dispatch[IDX_W+1:2];
    assign wr_tag = train.pc_dispatch[31:IDX_W+2];
    assign wr_en  = train_valid && train.update_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            // weakly not taken everywhere
            cnt_q       <= {ENTRIES{2'b01}};
            btb_valid_q <= '0;
        end else if (wr_en) begin
            if (train.taken_actual) begin
                if (cnt_q[wr_idx] != 2'b11) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
                end
                btb_valid_q[wr_idx] <= 1'b1;
            end else if (cnt_q[wr_idx] != 2'b00) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && train.taken_actual) begin
            btb_tag_q[wr_idx]    <= wr_tag;
            btb_target_q[wr_idx] <= train.actual_target;
        end
    end

    // every counter holds a known state once out of reset
    a_cnt_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(cnt_q))
        else $error("branch_predictor counter left the 2-bit range");

endmodule

/* branch_exec_stage.sv */
module branch_exec_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  branch_pkg::branch_req_t dispatch_req,
    output logic                    res_valid,
    input  logic                    res_ready,
    output branch_pkg::branch_res_t res_data
);
    import branch_pkg::*;

    branch_req_t    req_q;
    logic           valid_q;
    logic           accept;
    branch_update_t alu_update;
    logic           alu_flush;
    bus32_t         alu_redirect;
    bus32_t         alu_link;

    // free when empty or the held item leaves this cycle
    assign dispatch_ready = !valid_q || res_ready;
    assign accept         = dispatch_valid && dispatch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (res_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= dispatch_req;
        end
    end

    branch_alu branch_alu_i (
        .pc                  (req_q.pc),
        .inst                (req_q.inst),
        .aluop               (req_q.aluop),
        .reg1                (req_q.reg1),
        .reg2                (req_q.reg2),
        .pre_is_branch_taken (req_q.pred_taken),
        .pre_branch_addr     (req_q.pred_target),
        .update_info         (alu_update),
        .branch_flush        (alu_flush),
        .redirect_addr       (alu_redirect),
        .branch_alu_res      (alu_link)
    );

    assign res_valid = valid_q;
    assign res_data  = '{
        pc:            req_q.pc,
        link_value:    alu_link,
        flush:         alu_flush,
        redirect_addr: alu_redirect,
        update:        alu_update
    };

    // ##################################################
    // checks
    // ##################################################

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else $error("result changed while stalled");

    a_flush_trains: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_data.flush |-> res_data.update.update_en)
        else $error("flush without predictor update");

endmodule

/* branch_unit.sv */
module branch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  branch_pkg::branch_req_t dispatch_req,
    output logic                    res_valid,
    input  logic                    res_ready,
    output branch_pkg::branch_res_t res_data,
    input  branch_pkg::bus32_t      fetch_pc,
    output branch_pkg::prediction_t fetch_pred
);

    logic train_valid;

    branch_exec_stage branch_exec_stage_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_req   (dispatch_req),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_data       (res_data)
    );

    // the result handshake is the commit point for training
    assign train_valid = res_valid && res_ready;

    branch_predictor branch_predictor_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_pc    (fetch_pc),
        .fetch_pred  (fetch_pred),
        .train_valid (train_valid),
        .train       (res_data.update)
    );

endmodule

/* branch_checker.sv */
`include "branch_settings.svh"

module branch_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    input  logic                    dispatch_ready,
    input  branch_pkg::branch_req_t dispatch_req,
    input  logic                    res_valid,
    input  logic                    res_ready,
    input  branch_pkg::branch_res_t res_data,
    input  branch_pkg::bus32_t      fetch_pc,
    input  branch_pkg::prediction_t fetch_pred,
    output int                      error_count,
    output int                      check_count,
    output int                      dispatch_count,
    output int                      result_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import branch_pkg::*;

    localparam int IDX_W   = `BHT_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_W   = 30 - IDX_W;

    // mirror of the predictor state
    logic [1:0]       m_cnt    [ENTRIES];
    logic             m_valid  [ENTRIES];
    logic [TAG_W-1:0] m_tag    [ENTRIES];
    bus32_t           m_target [ENTRIES];

    branch_req_t pending [$];
    branch_req_t req;
    branch_res_t exp;
    branch_res_t held;
    prediction_t pred;
    logic        stalled;
    int          errs;
    int          checks;
    int          dispatched;
    int          resolved;

    // ##################################################
    // reference model
    // ##################################################

    function automatic branch_res_t expected(input branch_req_t r);
        branch_res_t e;
        logic [31:0] w;
        bus32_t      o16;
        bus32_t      o26;
        bus32_t      next_pc;
        bus32_t      tgt;
        logic        br;
        logic        tk;
        w       = r.inst;
        o16     = {{14{w[25]}}, w[25:10], 2'b00};
        // b and bl keep the high offset bits at the bottom of the word
        o26     = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        next_pc = r.pc + 32'd4;
        br      = 1'b1;
        tk      = 1'b0;
        tgt     = r.pc + o16;
        case (r.aluop)
            `ALU_BEQ:  tk = (r.reg1 == r.reg2);
            `ALU_BNE:  tk = (r.reg1 != r.reg2);
            `ALU_BLT:  tk = ($signed(r.reg1) < $signed(r.reg2));
            `ALU_BGE:  tk = ($signed(r.reg1) >= $signed(r.reg2));
            `ALU_BLTU: tk = (r.reg1 < r.reg2);
            `ALU_BGEU: tk = (r.reg1 >= r.reg2);
            `ALU_B, `ALU_BL: begin
                tk  = 1'b1;
                tgt = r.pc + o26;
            end
            `ALU_JIRL: begin
                tk  = 1'b1;
                tgt = r.reg1 + o16;
            end
            default: br = 1'b0;
        endcase
        e                      = '0;
        e.pc                   = r.pc;
        e.link_value           = (r.aluop == `ALU_BL || r.aluop == `ALU_JIRL) ? next_pc : '0;
        e.flush                = br && ((tk != r.pred_taken) ||
                                        (tk && r.pred_taken && tgt != r.pred_target));
        e.redirect_addr        = tk ? tgt : next_pc;
        e.update.update_en     = br;
        e.update.pc_dispatch   = r.pc;
        e.update.taken_actual  = tk;
        e.update.actual_target = tk ? tgt : '0;
        return e;
    endfunction

    function automatic prediction_t mirror_lookup(input bus32_t pc);
        prediction_t      p;
        logic [IDX_W-1:0] idx;
        idx      = pc[IDX_W+1:2];
        p.taken  = m_cnt[idx][1] && m_valid[idx] && (m_tag[idx] == pc[31:IDX_W+2]);
        p.target = p.taken ? m_target[idx] : '0;
        return p;
    endfunction

    task automatic train_mirror(input branch_update_t u);
        logic [IDX_W-1:0] idx;
        idx = u.pc_dispatch[IDX_W+1:2];
        if (u.taken_actual) begin
            if (m_cnt[idx] != 2'b11) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = u.pc_dispatch[31:IDX_W+2];
            m_target[idx] = u.actual_target;
        end else if (m_cnt[idx] != 2'b00) begin
            m_cnt[idx] = m_cnt[idx] - 2'd1;
        end
    endtask

    // ##################################################
    // compare at every rising edge
    // ##################################################

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                m_cnt[i]   = 2'b01;
                m_valid[i] = 1'b0;
            end
            pending.delete();
            stalled = 1'b0;
        end else begin
            pred = mirror_lookup(fetch_pc);
            checks++;
            if (fetch_pred !== pred) begin
                errs++;
                $display("error at %0t ns: prediction for pc %h is %b/%h, expected %b/%h",
                         $time, fetch_pc, fetch_pred.taken, fetch_pred.target,
                         pred.taken, pred.target);
            end
            // one-deep stage is free when empty or when its result leaves now
            checks++;
            if (dispatch_ready !== (pending.size() == 0 || res_ready)) begin
                errs++;
                $display("error at %0t ns: dispatch_ready is %b with %0d held, res_ready %b",
                         $time, dispatch_ready, pending.size(), res_ready);
            end
            if (stalled && (!res_valid || res_data !== held)) begin
                errs++;
                $display("the stalled result changed or vanished at %0t ns", $time);
            end
            if (res_valid && pending.size() == 0) begin
                errs++;
                $display("res_valid is high at %0t ns with no request outstanding", $time);
            end else if (res_valid && res_ready) begin
                req = pending.pop_front();
                exp = expected(req);
                resolved++;
                checks++;
                if (res_data !== exp) begin
                    errs++;
                    $display("error at %0t ns: pc %h op %h gave link %h flush %b redirect %h",
                             $time, req.pc, req.aluop, res_data.link_value, res_data.flush,
                             res_data.redirect_addr);
                    $display("    expected link %h flush %b redirect %h update_en %b",
                             exp.link_value, exp.flush, exp.redirect_addr,
                             exp.update.update_en);
                end
                // the predictor learns only from committed branches
                if (exp.update.update_en) begin
                    train_mirror(exp.update);
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                pending.push_back(dispatch_req);
                dispatched++;
            end
            stalled = res_valid && !res_ready;
            held    = res_data;
        end
        error_count    <= errs;
        check_count    <= checks;
        dispatch_count <= dispatched;
        result_count   <= resolved;
    end

endmodule

/* tb_branch_unit.sv */
`include "branch_settings.svh"

module tb_branch_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import branch_pkg::*;

    localparam int          TIMEOUT = 200;
    localparam logic [31:0] SEED    = 32'ha52b_fa34;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    logic        dispatch_ready;
    branch_req_t dispatch_req;
    logic        res_valid;
    logic        res_ready;
    branch_res_t res_data;
    bus32_t      fetch_pc;
    prediction_t fetch_pred;
    int          error_count;
    int          check_count;
    int          dispatch_count;
    int          result_count;
    logic [31:0] rng;
    bit          timed_out;

    // pcs 1c000000 and 1c000040 share a predictor entry with different tags
    bus32_t pc_set [8] = '{32'h1c00_0000, 32'h1c00_0004, 32'h1c00_0010, 32'h1c00_0040,
                           32'h1c00_0104, 32'h8000_003c, 32'h1c00_0020, 32'h1c00_0024};

    // weighted toward the compares that differ in signedness
    alu_op_t op_mix [16] = '{`ALU_NOP, `ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU,
                             `ALU_BGEU, `ALU_B, `ALU_BL, `ALU_JIRL, `ALU_BLT, `ALU_BGE,
                             `ALU_BLTU, `ALU_BGEU, `ALU_JIRL, `ALU_NOP};

    branch_unit branch_unit_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_req   (dispatch_req),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_data       (res_data),
        .fetch_pc       (fetch_pc),
        .fetch_pred     (fetch_pred)
    );

    branch_checker branch_checker_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_req   (dispatch_req),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_data       (res_data),
        .fetch_pc       (fetch_pc),
        .fetch_pred     (fetch_pred),
        .error_count    (error_count),
        .check_count    (check_count),
        .dispatch_count (dispatch_count),
        .result_count   (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ##################################################
    // stimulus helpers
    // ##################################################

    // one clock, with a fresh random back-pressure decision
    task automatic tick();
        @(posedge clk);
        rng = xorshift(rng);
        res_ready <= (rng[1:0] != 2'b00);
    endtask

    task automatic send_branch(input bus32_t pc, input alu_op_t op, input bus32_t word,
                               input bus32_t r1, input bus32_t r2);
        branch_req_t req;
        int          waited;
        if (timed_out) begin
            return;
        end
        // fetch looks the pc up one cycle ahead of dispatch
        fetch_pc <= pc;
        tick();
        req.pc          = pc;
        req.inst        = word;
        req.aluop       = op;
        req.reg1        = r1;
        req.reg2        = r2;
        req.pred_taken  = fetch_pred.taken;
        req.pred_target = fetch_pred.target;
        dispatch_valid <= 1'b1;
        dispatch_req   <= req;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (!dispatch_ready && waited < TIMEOUT);
        dispatch_valid <= 1'b0;
        if (!dispatch_ready) begin
            $display("timeout: dispatch_ready stayed low for %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        do begin
            tick();
            waited++;
        end while (result_count != dispatch_count && waited < TIMEOUT);
        if (result_count != dispatch_count) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     dispatch_count - result_count, TIMEOUT);
            timed_out = 1'b1;
        end
        tick();
        tick();
    endtask

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        logic [31:0] sel;
        logic [31:0] word;
        logic [31:0] r1;
        logic [31:0] r2;
        rng            = SEED;
        timed_out      = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        res_ready      = 1'b0;
        fetch_pc       = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // every lookup should miss right after reset
        for (int i = 0; i < 8; i++) begin
            fetch_pc <= pc_set[i];
            tick();
        end

        for (int i = 0; i < 300; i++) begin
            rng  = xorshift(rng);
            sel  = rng;
            rng  = xorshift(rng);
            word = rng;
            rng  = xorshift(rng);
            r1   = rng;
            rng  = xorshift(rng);
            r2   = (sel[7:4] == 4'd0) ? r1 : rng;
            send_branch(pc_set[sel[2:0]], op_mix[sel[11:8]], word, r1, r2);
        end

        // train one pc to taken, pass nops over it, then back to not taken
        for (int i = 0; i < 4; i++) begin
            send_branch(pc_set[5], `ALU_B, 32'h5000_0400, 32'h0, 32'h0);
        end
        for (int i = 0; i < 3; i++) begin
            send_branch(pc_set[5], `ALU_NOP, 32'h5000_0400, 32'h1, 32'h1);
        end
        for (int i = 0; i < 4; i++) begin
            send_branch(pc_set[5], `ALU_BEQ, 32'h5000_0400, 32'h1, 32'h2);
        end
        drain();

        $display("checks %0d, errors %0d, dispatched %0d, resolved %0d",
                 check_count, error_count, dispatch_count, result_count);
        if (!timed_out && error_count == 0 && dispatch_count == result_count) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
branch_pkg.sv
branch_alu.sv
branch_predictor.sv
branch_exec_stage.sv
branch_unit.sv
branch_checker.sv
tb_branch_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_branch_unit -f vlog.f

out=$(./obj_dir/Vtb_branch_unit 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
